/* filelist.f */
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/alu.sv
hdl/executeStage.sv
hdl/mipsCore.sv
tb/mipsCore_props.sv
tb/mipsCore_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
        input  mipsPkg::aluFunc_t  func,
        input        [31:0]        a,
        input        [31:0]        b,
        input        [4:0]         shamt,
        output logic [31:0]        y
);

        logic [31:0] product;

        // low word of the product
        assign product = a * b;

        always_comb begin
                case (func)
                        mipsPkg::aluAdd: begin
                                y = a + b;
                        end
                        mipsPkg::aluSub: begin
                                y = a - b;
                        end
                        mipsPkg::aluAnd: begin
                                y = a & b;
                        end
                        mipsPkg::aluOr: begin
                                y = a | b;
                        end
                        mipsPkg::aluXor: begin
                                y = a ^ b;
                        end
                        mipsPkg::aluSlt: begin
                                // signed compare
                                y = {31'd0, ($signed(a) < $signed(b))};
                        end
                        mipsPkg::aluSll: begin
                                y = b << shamt;
                        end
                        mipsPkg::aluSrl: begin
                                y = b >> shamt;
                        end
                        mipsPkg::aluSra: begin
                                y = $signed(b) >>> shamt;
                        end
                        mipsPkg::aluMul: begin
                                y = product;
                        end
                        default: begin
                                y = '0;
                        end
                endcase
        end

endmodule

/* hdl/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder (
        input  mipsPkg::instrWord_t instr,
        output mipsPkg::ctrl_t      ctrl
);

        localparam logic [5:0] opRType = 6'h00;
        localparam logic [5:0] opAddi  = 6'h08;
        localparam logic [5:0] opSlti  = 6'h0A;
        localparam logic [5:0] opAndi  = 6'h0C;
        localparam logic [5:0] opOri   = 6'h0D;
        localparam logic [5:0] opLui   = 6'h0F;

        // R-type function codes
        localparam logic [5:0] fnSll = 6'h00;
        localparam logic [5:0] fnSrl = 6'h02;
        localparam logic [5:0] fnSra = 6'h03;
        localparam logic [5:0] fnMul = 6'h18;
        localparam logic [5:0] fnAdd = 6'h20;
        localparam logic [5:0] fnSub = 6'h22;
        localparam logic [5:0] fnAnd = 6'h24;
        localparam logic [5:0] fnOr  = 6'h25;
        localparam logic [5:0] fnXor = 6'h26;
        localparam logic [5:0] fnSlt = 6'h2A;

        always_comb begin
                // anything not listed stays a no-op
                ctrl = '0;
                case (instr.iFmt.opcode)
                        opRType: begin
                                ctrl.regDst   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                case (instr.rFmt.funct)
                                        fnAdd:   ctrl.aluFunc = mipsPkg::aluAdd;
                                        fnSub:   ctrl.aluFunc = mipsPkg::aluSub;
                                        fnAnd:   ctrl.aluFunc = mipsPkg::aluAnd;
                                        fnOr:    ctrl.aluFunc = mipsPkg::aluOr;
                                        fnXor:   ctrl.aluFunc = mipsPkg::aluXor;
                                        fnSlt:   ctrl.aluFunc = mipsPkg::aluSlt;
                                        fnSll:   ctrl.aluFunc = mipsPkg::aluSll;
                                        fnSrl:   ctrl.aluFunc = mipsPkg::aluSrl;
                                        fnSra:   ctrl.aluFunc = mipsPkg::aluSra;
                                        fnMul:   ctrl.aluFunc = mipsPkg::aluMul;
                                        default: ctrl = '0;
                                endcase
                        end
                        opAddi, opAndi, opOri, opSlti, opLui: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                case (instr.iFmt.opcode)
                                        opAndi:  ctrl.aluFunc = mipsPkg::aluAnd;
                                        opOri:   ctrl.aluFunc = mipsPkg::aluOr;
                                        opSlti:  ctrl.aluFunc = mipsPkg::aluSlt;
                                        default: ctrl.aluFunc = mipsPkg::aluAdd;
                                endcase
                                // lui is an add of zero to the shifted immediate
                                ctrl.upperImm = (instr.iFmt.opcode == opLui);
                        end
                        default: ctrl = '0;
                endcase
        end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
        input                          Clock,
        input                          rst,
        input                          instrValid,
        input  mipsPkg::instrWord_t    instr,
        input  mipsPkg::wbBus_t        wbIn,
        output mipsPkg::decExe_t       decOut
);

        mipsPkg::ctrl_t ctrl;
        logic [31:0]    rsRead;
        logic [31:0]    rtRead;
        logic [31:0]    immData;
        logic [31:0]    rsData;
        logic [4:0]     destAddr;

        controlDecoder dec0 (
                .instr (instr),
                .ctrl  (ctrl)
        );

        // writeback from the execute stage lands here
        regFile reg0 (
                .Clock  (Clock),
                .rst    (rst),
                .wbIn   (wbIn),
                .rsAddr (instr.iFmt.rs),
                .rtAddr (instr.iFmt.rt),
                .rsData (rsRead),
                .rtData (rtRead)
        );

        always_comb begin
                if (ctrl.upperImm)
                        immData = {instr.iFmt.imm16, 16'h0000};
                else
                        immData = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
        end

        // I-type writes rt, R-type writes rd
        assign destAddr = ctrl.regDst ? instr.rFmt.rd : instr.iFmt.rt;

        // lui adds the upper immediate to zero
        assign rsData = ctrl.upperImm ? 32'd0 : rsRead;

        always_ff @(posedge Clock) begin
                if (rst)
                        decOut.valid <= 1'b0;
                else
                        decOut.valid <= instrValid;

                decOut.ctrl     <= ctrl;
                decOut.rsData   <= rsData;
                decOut.rtData   <= rtRead;
                decOut.immData  <= immData;
                decOut.shamt    <= instr.rFmt.shamt;
                decOut.destAddr <= destAddr;
        end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
        input                          Clock,
        input                          rst,
        input  mipsPkg::decExe_t       decIn,
        output mipsPkg::wbBus_t        wbOut
);

        logic [31:0] opB;
        logic [31:0] aluY;
        logic        writeEn;

        // immediate forms take the second operand from immData
        assign opB = decIn.ctrl.aluSrc ? decIn.immData : decIn.rtData;

        alu alu0 (
                .func  (decIn.ctrl.aluFunc),
                .a     (decIn.rsData),
                .b     (opB),
                .shamt (decIn.shamt),
                .y     (aluY)
        );

        // writes to r0 never leave the core
        assign writeEn = decIn.valid && decIn.ctrl.regWrite && (decIn.destAddr != 5'd0);

        always_ff @(posedge Clock) begin
                if (rst)
                        wbOut.valid <= 1'b0;
                else
                        wbOut.valid <= writeEn;

                wbOut.addr <= decIn.destAddr;
                wbOut.data <= aluY;
        end

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
        input                          Clock,
        input                          rst,
        input  logic                   instrValid,
        input  mipsPkg::instrWord_t    instr,
        output mipsPkg::wbBus_t        wb
);

        mipsPkg::decExe_t decExe;

        // wb also closes the loop into the register file
        decodeStage decode0 (
                .Clock      (Clock),
                .rst        (rst),
                .instrValid (instrValid),
                .instr      (instr),
                .wbIn       (wb),
                .decOut     (decExe)
        );

        executeStage execute0 (
                .Clock (Clock),
                .rst   (rst),
                .decIn (decExe),
                .wbOut (wb)
        );

endmodule

/* hdl/mipsPkg.sv */
package mipsPkg;

        // register-format view of an instruction word
        typedef struct packed {
                logic [5:0] opcode;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [4:0] rd;
                logic [4:0] shamt;
                logic [5:0] funct;
        } rFmt_t;

        // immediate-format view of the same word
        typedef struct packed {
                logic [5:0]  opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm16;
        } iFmt_t;

        typedef union packed {
                rFmt_t rFmt;
                iFmt_t iFmt;
        } instrWord_t;

        typedef enum logic [3:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluXor,
                aluSlt,
                aluSll,
                aluSrl,
                aluSra,
                aluMul
        } aluFunc_t;

        typedef struct packed {
                logic     regDst;
                logic     aluSrc;
                logic     upperImm;
                logic     regWrite;
                aluFunc_t aluFunc;
        } ctrl_t;

        // decode to execute boundary
        typedef struct packed {
                logic        valid;
                ctrl_t       ctrl;
                logic [31:0] rsData;
                logic [31:0] rtData;
                logic [31:0] immData;
                logic [4:0]  shamt;
                logic [4:0]  destAddr;
        } decExe_t;

        // writeback strobe, also the core output
        typedef struct packed {
                logic        valid;
                logic [4:0]  addr;
                logic [31:0] data;
        } wbBus_t;

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
        input                      Clock,
        input                      rst,
        input  mipsPkg::wbBus_t    wbIn,
        input        [4:0]         rsAddr,
        input        [4:0]         rtAddr,
        output logic [31:0]        rsData,
        output logic [31:0]        rtData
);

        // register zero has no storage
        logic [31:0] regs [1:31];

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end
                else if (wbIn.valid && (wbIn.addr != 5'd0)) begin
                        regs[wbIn.addr] <= wbIn.data;
                end
        end

        // reads are combinational, zero reads back as zero
        always_comb begin
                if (rsAddr == 5'd0)
                        rsData = '0;
                else
                        rsData = regs[rsAddr];

                if (rtAddr == 5'd0)
                        rtData = '0;
                else
                        rtData = regs[rtAddr];
        end

endmodule

/* tb/mipsCore_props.sv */
`timescale 1ns/1ps

module mipsCore_props (
        input                  Clock,
        input                  rst,
        input                  instrValid,
        input mipsPkg::wbBus_t wb
);

        // assertion failures seen so far
        int failCount = 0;

        // nothing leaves the core while it is reset or in the two cycles after
        quietAfterReset: assert property (@(posedge Clock) rst |=> !wb.valid ##1 !wb.valid)
                else begin
                        $error("writeback strobe during or just after reset");
                        failCount++;
                end

        // two-stage latency from the issue strobe
        issueLatency: assert property (@(posedge Clock) wb.valid |-> $past(instrValid, 2))
                else begin
                        $error("writeback strobe without an issue two cycles earlier");
                        failCount++;
                end

        // writes to r0 are dropped inside the core
        noZeroDest: assert property (@(posedge Clock) wb.valid |-> wb.addr != 5'd0)
                else begin
                        $error("writeback strobe addressed to register zero");
                        failCount++;
                end

endmodule

bind mipsCore mipsCore_props props0 (
        .Clock      (Clock),
        .rst        (rst),
        .instrValid (instrValid),
        .wb         (wb)
);

/* tb/mipsCore_tb.sv */
`timescale 1ns/1ps

module mipsCore_tb;

        typedef struct {
                logic [31:0] word;
                int          gap;
                logic        isReset;
                logic        expWb;
                logic [4:0]  addr;
                logic [31:0] data;
        } stimRow_t;

        typedef struct {
                logic [4:0]  addr;
                logic [31:0] data;
                int          due;
        } expEntry_t;

        localparam int nRand = 150;
        // R-type funct codes followed by the I-type opcodes
        localparam logic [5:0] codes [15] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2A, 6'h00,
                6'h02, 6'h03, 6'h18, 6'h08, 6'h0C, 6'h0D, 6'h0A, 6'h0F};

        logic                Clock = 1'b0;
        logic                rst = 1'b1;
        logic                instrValid = 1'b0;
        mipsPkg::instrWord_t instr = '0;
        mipsPkg::wbBus_t     wb;

        stimRow_t    tbl [32];
        int          nRows = 0;
        expEntry_t   expQ [$];
        expEntry_t   popped;
        logic [31:0] refRegs [8];
        logic [31:0] lfsr = 32'hb3f3ec28;
        int          cyc = 0;
        int          errors = 0;
        int          limit = 0;

        mipsCore DUT (.Clock(Clock), .rst(rst), .instrValid(instrValid),
                .instr(instr), .wb(wb));

        initial begin
                forever #5 Clock = ~Clock;
        end

        always @(posedge Clock) begin
                cyc <= cyc + 1;
        end

        // Galois LFSR stepped once per bit drawn
        function automatic logic [31:0] randBits(input int n);
                logic [31:0] v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
                        v = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        function automatic logic [31:0] rType(logic [5:0] fn, logic [4:0] rs, rt, rd, sh);
                return {6'h00, rs, rt, rd, sh, fn};
        endfunction

        function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, rt,
                        logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        // one-cycle strobe followed by idle cycles up to the gap
        task automatic issue(input logic [31:0] w, input int gap, input logic expWb,
                        input logic [4:0] addr, input logic [31:0] data);
                instrValid = 1'b1;
                instr = w;
                if (expWb)
                        expQ.push_back(expEntry_t'{addr, data, cyc + 2});
                repeat (gap) begin
                        @(posedge Clock);
                        #1 instrValid = 1'b0;
                end
        endtask

        task automatic addRow(logic [31:0] w, int gap, logic rstRow, logic expWb,
                        logic [4:0] addr, logic [31:0] data);
                tbl[nRows] = '{w, gap, rstRow, expWb, addr, data};
                nRows++;
        endtask

        // random instruction over r1..r7 predicted from the reference registers
        task automatic genRandom(output logic [31:0] w, output logic [4:0] dst,
                        output logic [31:0] res);
                int          sel;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  sh;
                logic [15:0] imm;
                logic [31:0] ext;
                sel = int'(randBits(4) % 15);
                rs = 5'(1 + randBits(3) % 7);
                rt = 5'(1 + randBits(3) % 7);
                dst = (sel < 10) ? 5'(1 + randBits(3) % 7) : rt;
                sh = 5'(randBits(5));
                imm = 16'(randBits(16));
                ext = {{16{imm[15]}}, imm};
                w = (sel < 10) ? rType(codes[sel], rs, rt, dst, sh)
                        : iType(codes[sel], rs, rt, imm);
                case (sel)
                        0: res = refRegs[rs] + refRegs[rt];
                        1: res = refRegs[rs] - refRegs[rt];
                        2: res = refRegs[rs] & refRegs[rt];
                        3: res = refRegs[rs] | refRegs[rt];
                        4: res = refRegs[rs] ^ refRegs[rt];
                        5: res = {31'd0, $signed(refRegs[rs]) < $signed(refRegs[rt])};
                        6: res = refRegs[rt] << sh;
                        7: res = refRegs[rt] >> sh;
                        8: res = $signed(refRegs[rt]) >>> sh;
                        9: res = refRegs[rs] * refRegs[rt];
                        10: res = refRegs[rs] + ext;
                        11: res = refRegs[rs] & ext;
                        12: res = refRegs[rs] | ext;
                        13: res = {31'd0, $signed(refRegs[rs]) < $signed(ext)};
                        default: res = {imm, 16'h0000};
                endcase
                refRegs[dst] = res;
        endtask

        // writeback monitor sampled at the falling edge
        always @(negedge Clock) begin
                if (wb.valid === 1'b1 && expQ.size() == 0) begin
                        $display("ERROR t=%0t unexpected writeback to r%0d", $time, wb.addr);
                        errors++;
                end
                else if (wb.valid === 1'b1) begin
                        popped = expQ.pop_front();
                        if (popped.due != cyc) begin
                                $display("ERROR t=%0t writeback came in cycle %0d, due in %0d",
                                        $time, cyc, popped.due);
                                errors++;
                        end
                        checkVal("wb.addr", wb.addr, popped.addr);
                        checkVal("wb.data", wb.data, popped.data);
                end
                else if (expQ.size() != 0 && expQ[0].due <= cyc) begin
                        popped = expQ.pop_front();
                        $display("ERROR t=%0t no writeback for r%0d", $time, popped.addr);
                        errors++;
                end
        end

        initial begin
                logic [31:0] w;
                logic [4:0]  dst;
                logic [31:0] res;
                int          total;
                // immediates and r0 as a destination
                addRow(iType(6'h0F, 0, 1, 16'h8000), 1, 0, 1, 1, 32'h8000_0000);
                addRow(iType(6'h0D, 0, 2, 16'h1234), 1, 0, 1, 2, 32'h0000_1234);
                addRow(iType(6'h08, 0, 3, 16'hFFFB), 1, 0, 1, 3, 32'hFFFF_FFFB);
                addRow(iType(6'h08, 0, 4, 16'h0064), 1, 0, 1, 4, 32'h0000_0064);
                addRow(iType(6'h08, 0, 0, 16'h0007), 1, 0, 0, 0, 32'h0000_0000);
                addRow(iType(6'h0D, 0, 6, 16'h8001), 3, 0, 1, 6, 32'hFFFF_8001);
                // R-type ALU issued back to back
                addRow(rType(6'h20, 3, 4, 7, 0), 1, 0, 1, 7, 32'h0000_005F);
                addRow(rType(6'h22, 3, 4, 8, 0), 1, 0, 1, 8, 32'hFFFF_FF97);
                addRow(rType(6'h24, 3, 4, 9, 0), 1, 0, 1, 9, 32'h0000_0060);
                addRow(rType(6'h25, 2, 4, 10, 0), 1, 0, 1, 10, 32'h0000_1274);
                addRow(rType(6'h26, 2, 6, 11, 0), 1, 0, 1, 11, 32'hFFFF_9235);
                addRow(rType(6'h2A, 1, 2, 12, 0), 1, 0, 1, 12, 32'h0000_0001);
                addRow(rType(6'h2A, 4, 3, 13, 0), 1, 0, 1, 13, 32'h0000_0000);
                addRow(rType(6'h20, 0, 4, 14, 0), 1, 0, 1, 14, 32'h0000_0064);
                // shifts of a negative operand and the multiply low word
                addRow(rType(6'h00, 0, 3, 16, 4), 1, 0, 1, 16, 32'hFFFF_FFB0);
                addRow(rType(6'h02, 0, 3, 17, 8), 1, 0, 1, 17, 32'h00FF_FFFF);
                addRow(rType(6'h03, 0, 3, 18, 2), 1, 0, 1, 18, 32'hFFFF_FFFE);
                addRow(rType(6'h03, 0, 1, 19, 31), 1, 0, 1, 19, 32'hFFFF_FFFF);
                addRow(rType(6'h18, 6, 2, 20, 0), 3, 0, 1, 20, 32'hF6E6_1234);
                // dependent chain three cycles apart
                addRow(iType(6'h08, 0, 21, 16'h0003), 3, 0, 1, 21, 32'h0000_0003);
                addRow(rType(6'h20, 21, 21, 22, 0), 3, 0, 1, 22, 32'h0000_0006);
                addRow(rType(6'h00, 0, 22, 23, 3), 3, 0, 1, 23, 32'h0000_0030);
                // undefined opcode followed by a reset that clears the register file
                addRow(iType(6'h3F, 1, 25, 16'h1234), 3, 0, 0, 0, 32'h0000_0000);
                addRow(32'd0, 3, 1, 0, 0, 32'h0000_0000);
                addRow(rType(6'h20, 1, 3, 8, 0), 3, 0, 1, 8, 32'h0000_0000);
                total = 3 + nRand * 3 + 20;
                for (int i = 0; i < nRows; i++) begin
                        total += tbl[i].gap;
                end
                limit = total;
                repeat (3) @(posedge Clock);
                #1 rst = 1'b0;
                for (int i = 0; i < nRows; i++) begin
                        if (tbl[i].isReset) begin
                                rst = 1'b1;
                                repeat (3) @(posedge Clock);
                                #1 rst = 1'b0;
                        end
                        else begin
                                issue(tbl[i].word, tbl[i].gap, tbl[i].expWb, tbl[i].addr,
                                        tbl[i].data);
                        end
                end
                // the reset row left r1..r7 at zero
                foreach (refRegs[k])
                        refRegs[k] = '0;
                for (int k = 0; k < nRand; k++) begin
                        genRandom(w, dst, res);
                        issue(w, 3, 1'b1, dst, res);
                end
                repeat (4) @(posedge Clock);
                errors += DUT.props0.failCount;
                $display("summary: %0d errors", errors);
                if (errors == 0)
                        $display("TESTS PASSED");
                else
                        $display("TESTS FAILED");
                $finish;
        end

        initial begin
                wait (limit > 0);
                #(limit * 10);
                $display("ERROR watchdog expired after %0d cycles", limit);
                $display("TESTS FAILED");
                $finish;
        end

endmodule
